/* src/cp0Pkg.sv */
package cp0Pkg;

    // exception codes as seen in Cause[6:2]
    typedef enum logic [4:0] {
        excInt  = 5'd0,
        excAdEL = 5'd4,
        excAdES = 5'd5,
        excSys  = 5'd8,
        excRI   = 5'd10,
        excOv   = 5'd12
    } excCodeE;

    // coprocessor register numbers
    typedef enum logic [4:0] {
        regSR    = 5'd12,
        regCause = 5'd13,
        regEPC   = 5'd14
    } cp0AddrE;

    // timer register index on the small timer port
    typedef enum logic [1:0] {
        tmrCtrl   = 2'd0,
        tmrPreset = 2'd1,
        tmrCount  = 2'd2
    } timerRegE;

    // Status fields
    localparam int srIeBit  = 0;
    localparam int srExlBit = 1;
    localparam int srMaskLo = 10;
    localparam int srMaskHi = 15;

    // Cause fields
    localparam int causeBdBit  = 31;
    localparam int causeCodeLo = 2;
    localparam int causeCodeHi = 6;

    // where the timer and generator sit in hwInt
    localparam int timerIntBit = 10;
    localparam int genIntBit   = 12;

endpackage

/* src/excEncoder.sv */
// commit-stage exception info toward the coprocessor
interface excIf;
    logic [31:0]          pc;
    logic                 bd;
    cp0Pkg::excCodeE      excCode;
    logic                 exlClr;

    modport source (output pc, output bd, output excCode, output exlClr);
    modport sink   (input pc, input bd, input excCode, input exlClr);
endinterface

module excEncoder (
    input  logic [31:0] pc,
    input  logic        bd,
    input  logic        riFault,
    input  logic        syscall,
    input  logic        overflow,
    input  logic        loadAddrErr,
    input  logic        storeAddrErr,
    input  logic        eret,
    excIf.source        exc
);

    logic pcMisaligned;
    logic anyFault;

    // fetch from a non-word address
    assign pcMisaligned = |pc[1:0];

    assign anyFault = pcMisaligned | riFault | syscall | overflow
                    | loadAddrErr | storeAddrErr;

    // fixed priority, fetch fault first
    always_comb begin
        if (pcMisaligned) begin
            exc.excCode = cp0Pkg::excAdEL;
        end else if (riFault) begin
            exc.excCode = cp0Pkg::excRI;
        end else if (syscall) begin
            exc.excCode = cp0Pkg::excSys;
        end else if (overflow) begin
            exc.excCode = cp0Pkg::excOv;
        end else if (loadAddrErr) begin
            exc.excCode = cp0Pkg::excAdEL;
        end else if (storeAddrErr) begin
            exc.excCode = cp0Pkg::excAdES;
        end else begin
            // zero means nothing to report
            exc.excCode = cp0Pkg::excInt;
        end
    end

    // a faulting eret does not return
    assign exc.exlClr = eret & ~anyFault;

    // commit pc and delay-slot flag go straight through
    assign exc.pc = pc;
    assign exc.bd = bd;

endmodule

/* src/cp0Regs.sv */
module cp0Regs (
    input  logic         clk,
    input  logic         reset,
    input  logic [4:0]   cp0Addr,
    input  logic [31:0]  cp0Wdata,
    input  logic         cp0We,
    excIf.sink           exc,
    input  logic [15:10] hwInt,
    output logic [31:0]  cp0Rdata,
    output logic [31:0]  epc,
    output logic         req,
    output logic         genAck
);

    logic [31:0]  sr;
    logic [31:0]  cause;
    logic [31:0]  epcQ;

    logic [15:10] intMask;
    logic         exl;
    logic         ie;
    logic         excTaken;
    logic         intTaken;

    // Status field views
    assign intMask = sr[cp0Pkg::srMaskHi:cp0Pkg::srMaskLo];
    assign exl     = sr[cp0Pkg::srExlBit];
    assign ie      = sr[cp0Pkg::srIeBit];

    // synchronous exception only outside a handler
    assign excTaken = (exc.excCode != cp0Pkg::excInt) & ~exl;

    // any enabled line while interrupts are on
    assign intTaken = (|(hwInt & intMask)) & ie & ~exl;

    assign req = excTaken | intTaken;

    // the generator wants its ack once we will service it
    assign genAck = hwInt[cp0Pkg::genIntBit] & sr[cp0Pkg::genIntBit] & ie & ~exl;

    always_ff @(posedge clk) begin
        if (reset) begin
            sr    <= '0;
            cause <= '0;
            epcQ  <= '0;
        end else begin
            // pending field tracks the lines every cycle
            cause[cp0Pkg::srMaskHi:cp0Pkg::srMaskLo] <= hwInt;

            // eret leaves the handler
            if (exc.exlClr) begin
                sr[cp0Pkg::srExlBit] <= 1'b0;
            end

            if (req) begin
                sr[cp0Pkg::srExlBit] <= 1'b1;
                cause[cp0Pkg::causeBdBit] <= exc.bd;
                // interrupt wins the code field when both fire
                cause[cp0Pkg::causeCodeHi:cp0Pkg::causeCodeLo] <=
                    intTaken ? cp0Pkg::excInt : exc.excCode;
                // delay slot restarts at the branch
                epcQ <= exc.bd ? (exc.pc - 32'd4) : exc.pc;
            end else if (cp0We) begin
                // Cause stays read-only to software
                case (cp0Addr)
                    cp0Pkg::regSR: begin
                        sr <= cp0Wdata;
                    end
                    cp0Pkg::regEPC: begin
                        epcQ <= cp0Wdata;
                    end
                    default: begin
                        // Cause and unmapped numbers ignore writes
                    end
                endcase
            end
        end
    end

    // software read port
    always_comb begin
        case (cp0Addr)
            cp0Pkg::regSR: begin
                cp0Rdata = sr;
            end
            cp0Pkg::regCause: begin
                cp0Rdata = cause;
            end
            cp0Pkg::regEPC: begin
                cp0Rdata = epcQ;
            end
            default: begin
                // unmapped numbers read as zero
                cp0Rdata = 32'd0;
            end
        endcase
    end

    assign epc = epcQ;

endmodule

/* src/countTimer.sv */
module countTimer #(
    parameter int TIMER_WIDTH = 32
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [1:0]  tmrAddr,
    input  logic [31:0] tmrWdata,
    input  logic        tmrWe,
    output logic [31:0] tmrRdata,
    output logic        timerIrq
);

    typedef enum logic [1:0] {
        tmrIdle,
        tmrLoad,
        tmrCount,
        tmrInt
    } tmrStateE;

    tmrStateE               state;
    logic [3:0]             ctrl;
    logic [TIMER_WIDTH-1:0] preset;
    logic [TIMER_WIDTH-1:0] count;

    logic                   ctrlWrite;
    logic                   autoReload;
    logic                   irqMask;

    assign ctrlWrite  = tmrWe & (tmrAddr == cp0Pkg::tmrCtrl);
    // bit 1 selects auto-reload, bit 3 lets the interrupt out
    assign autoReload = ctrl[1];
    assign irqMask    = ctrl[3];

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= tmrIdle;
            ctrl   <= '0;
            preset <= '0;
            count  <= '0;
        end else begin
            if (tmrWe && tmrAddr == cp0Pkg::tmrPreset) begin
                preset <= tmrWdata[TIMER_WIDTH-1:0];
            end

            if (ctrlWrite) begin
                ctrl <= tmrWdata[3:0];
                // enable bit restarts from preset, clear bit stops
                if (tmrWdata[0]) begin
                    count <= preset;
                    state <= tmrLoad;
                end else begin
                    state <= tmrIdle;
                end
            end else begin
                case (state)
                    tmrLoad: begin
                        state <= tmrCount;
                    end
                    tmrCount: begin
                        if (count != '0) begin
                            count <= count - 1'b1;
                        end else begin
                            state <= tmrInt;
                        end
                    end
                    tmrInt: begin
                        // one-shot holds here until control is rewritten
                        if (autoReload) begin
                            count <= preset;
                            state <= tmrLoad;
                        end
                    end
                    default: begin
                        state <= tmrIdle;
                    end
                endcase
            end
        end
    end

    // count is zero whenever we sit in tmrInt
    assign timerIrq = irqMask & (state == tmrInt);

    always_comb begin
        case (tmrAddr)
            cp0Pkg::tmrCtrl: begin
                tmrRdata = {28'd0, ctrl};
            end
            cp0Pkg::tmrPreset: begin
                tmrRdata = 32'(preset);
            end
            cp0Pkg::tmrCount: begin
                tmrRdata = 32'(count);
            end
            default: begin
                tmrRdata = 32'd0;
            end
        endcase
    end

endmodule

/* src/intSources.sv */
module intSources (
    input  logic         clk,
    input  logic         reset,
    input  logic [3:0]   extIrq,
    input  logic         genPulse,
    input  logic         genAck,
    input  logic         timerIrq,
    output logic [15:10] hwInt
);

    logic [3:0] extMeta;
    logic [3:0] extSync;
    logic       genPending;

    // two-stage synchronizer for the external lines
    always_ff @(posedge clk) begin
        if (reset) begin
            extMeta <= '0;
            extSync <= '0;
        end else begin
            extMeta <= extIrq;
            extSync <= extMeta;
        end
    end

    // generator latch, a new pulse beats the ack
    always_ff @(posedge clk) begin
        if (reset) begin
            genPending <= 1'b0;
        end else if (genPulse) begin
            genPending <= 1'b1;
        end else if (genAck) begin
            genPending <= 1'b0;
        end
    end

    // fixed line positions
    assign hwInt[cp0Pkg::timerIntBit] = timerIrq;
    assign hwInt[11]                  = extSync[0];
    assign hwInt[cp0Pkg::genIntBit]   = genPending;
    assign hwInt[13]                  = extSync[1];
    assign hwInt[14]                  = extSync[2];
    assign hwInt[15]                  = extSync[3];

endmodule

/* src/excUnit.sv */
module excUnit #(
    parameter int TIMER_WIDTH = 32
) (
    input  logic        clk,
    input  logic        reset,
    // commit stage
    input  logic [31:0] pc,
    input  logic        bd,
    input  logic        riFault,
    input  logic        syscall,
    input  logic        overflow,
    input  logic        loadAddrErr,
    input  logic        storeAddrErr,
    input  logic        eret,
    // coprocessor access
    input  logic [4:0]  cp0Addr,
    input  logic [31:0] cp0Wdata,
    input  logic        cp0We,
    // timer access
    input  logic [1:0]  tmrAddr,
    input  logic [31:0] tmrWdata,
    input  logic        tmrWe,
    // interrupt sources
    input  logic [3:0]  extIrq,
    input  logic        genPulse,
    output logic [31:0] cp0Rdata,
    output logic [31:0] epc,
    output logic        req,
    output logic        genAck,
    output logic [31:0] tmrRdata
);

    logic [15:10] hwInt;
    logic         timerIrq;

    excIf excBus ();

    excEncoder i_excEncoder (
        .pc           (pc),
        .bd           (bd),
        .riFault      (riFault),
        .syscall      (syscall),
        .overflow     (overflow),
        .loadAddrErr  (loadAddrErr),
        .storeAddrErr (storeAddrErr),
        .eret         (eret),
        .exc          (excBus.source)
    );

    cp0Regs i_cp0Regs (
        .clk      (clk),
        .reset    (reset),
        .cp0Addr  (cp0Addr),
        .cp0Wdata (cp0Wdata),
        .cp0We    (cp0We),
        .exc      (excBus.sink),
        .hwInt    (hwInt),
        .cp0Rdata (cp0Rdata),
        .epc      (epc),
        .req      (req),
        .genAck   (genAck)
    );

    countTimer #(
        .TIMER_WIDTH (TIMER_WIDTH)
    ) i_countTimer (
        .clk      (clk),
        .reset    (reset),
        .tmrAddr  (tmrAddr),
        .tmrWdata (tmrWdata),
        .tmrWe    (tmrWe),
        .tmrRdata (tmrRdata),
        .timerIrq (timerIrq)
    );

    // genAck also clears the generator latch
    intSources i_intSources (
        .clk      (clk),
        .reset    (reset),
        .extIrq   (extIrq),
        .genPulse (genPulse),
        .genAck   (genAck),
        .timerIrq (timerIrq),
        .hwInt    (hwInt)
    );

endmodule

/* dv/excUnitTb.sv */
module excUnitTb;

    // countdown preset for the timer test
    localparam int timerN = 6;
    // rough length of all tests in cycles, watchdog doubles it plus slack
    localparam int testCycles     = 170;
    localparam int watchdogCycles = 2 * testCycles + 60;

    // MIPS exception codes
    localparam logic [4:0] codeAdEL = 5'd4;
    localparam logic [4:0] codeAdES = 5'd5;
    localparam logic [4:0] codeSys  = 5'd8;
    localparam logic [4:0] codeRI   = 5'd10;
    localparam logic [4:0] codeOv   = 5'd12;

    // one bit per fault input
    localparam logic [4:0] fRi    = 5'b00001;
    localparam logic [4:0] fSys   = 5'b00010;
    localparam logic [4:0] fOv    = 5'b00100;
    localparam logic [4:0] fLoad  = 5'b01000;
    localparam logic [4:0] fStore = 5'b10000;

    logic        clk;
    logic        reset;
    logic [31:0] pc;
    logic        bd;
    logic [4:0]  faults;
    logic        eret;
    logic [4:0]  cp0Addr;
    logic [31:0] cp0Wdata;
    logic        cp0We;
    logic [1:0]  tmrAddr;
    logic [31:0] tmrWdata;
    logic        tmrWe;
    logic [3:0]  extIrq;
    logic        genPulse;
    logic [31:0] cp0Rdata;
    logic [31:0] epc;
    logic        req;
    logic        genAck;
    logic [31:0] tmrRdata;

    int errors;
    int checks;
    int seed;

    excUnit #(
        .TIMER_WIDTH (32)
    ) i_excUnit (
        .clk          (clk),
        .reset        (reset),
        .pc           (pc),
        .bd           (bd),
        .riFault      (faults[0]),
        .syscall      (faults[1]),
        .overflow     (faults[2]),
        .loadAddrErr  (faults[3]),
        .storeAddrErr (faults[4]),
        .eret         (eret),
        .cp0Addr      (cp0Addr),
        .cp0Wdata     (cp0Wdata),
        .cp0We        (cp0We),
        .tmrAddr      (tmrAddr),
        .tmrWdata     (tmrWdata),
        .tmrWe        (tmrWe),
        .extIrq       (extIrq),
        .genPulse     (genPulse),
        .cp0Rdata     (cp0Rdata),
        .epc          (epc),
        .req          (req),
        .genAck       (genAck),
        .tmrRdata     (tmrRdata)
    );

    always #2 clk = ~clk;

    task automatic expectEq(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
        checks++;
        assert (actVal === expVal) else begin
            $display("[ERROR] %s expected %h actual %h", name, expVal, actVal);
            errors++;
        end
    endtask

    function automatic logic [31:0] randPc();
        // word aligned
        randPc = $random(seed) & 32'hffff_fffc;
    endfunction

    function automatic logic randBit();
        randBit = $random(seed);
    endfunction

    // write lands on the second edge
    task automatic cp0Write(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk);
        cp0Addr  <= addr;
        cp0Wdata <= data;
        cp0We    <= 1'b1;
        @(posedge clk);
        cp0We    <= 1'b0;
    endtask

    // read port is combinational
    task automatic cp0ReadCheck(input string name, input logic [4:0] addr,
                                input logic [31:0] expVal);
        @(posedge clk);
        cp0Addr <= addr;
        @(negedge clk);
        expectEq(name, expVal, cp0Rdata);
    endtask

    task automatic tmrWrite(input logic [1:0] addr, input logic [31:0] data);
        @(posedge clk);
        tmrAddr  <= addr;
        tmrWdata <= data;
        tmrWe    <= 1'b1;
        @(posedge clk);
        tmrWe    <= 1'b0;
    endtask

    task automatic waitReq(input string name, input int maxCycles);
        for (int i = 0; i < maxCycles; i++) begin
            @(negedge clk);
            if (req === 1'b1) begin
                break;
            end
        end
        checks++;
        assert (req === 1'b1) else begin
            $display("%s: req did not rise within %0d cycles", name, maxCycles);
            errors++;
        end
    endtask

    task automatic reqStaysLow(input string name, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            expectEq(name, 32'd0, req);
        end
    endtask

    // tmrAddr must already point at the count register
    task automatic waitCount(input string name, input logic [31:0] value,
                             input int maxCycles);
        for (int i = 0; i < maxCycles; i++) begin
            @(negedge clk);
            if (tmrRdata === value) begin
                break;
            end
        end
        checks++;
        assert (tmrRdata === value) else begin
            $display("%s: timer count never reached %0d within %0d cycles",
                     name, value, maxCycles);
            errors++;
        end
    endtask

    // one fault in one cycle, then inspect Cause, EPC and SR
    task automatic faultEntry(input string name, input logic [4:0] flags,
                              input logic [31:0] pcVal, input logic bdVal,
                              input logic [4:0] code);
        logic [31:0] expEpc;
        // delay slot restarts at the branch
        expEpc = bdVal ? (pcVal - 32'd4) : pcVal;
        cp0Write(cp0Pkg::regSR, 32'd0);
        @(posedge clk);
        faults <= flags;
        pc     <= pcVal;
        bd     <= bdVal;
        @(negedge clk);
        expectEq({name, " req"}, 32'd1, req);
        @(posedge clk);
        faults <= 5'd0;
        pc     <= 32'd0;
        bd     <= 1'b0;
        cp0ReadCheck({name, " Cause"}, cp0Pkg::regCause, {bdVal, 24'd0, code, 2'b00});
        cp0ReadCheck({name, " EPC"}, cp0Pkg::regEPC, expEpc);
        expectEq({name, " epc port"}, expEpc, epc);
        // only EXL set
        cp0ReadCheck({name, " SR"}, cp0Pkg::regSR, 32'h0000_0002);
    endtask

    task automatic testRegAccess();
        cp0Write(cp0Pkg::regSR, 32'h1234_5600);
        cp0ReadCheck("regAccess SR", cp0Pkg::regSR, 32'h1234_5600);
        cp0Write(cp0Pkg::regEPC, 32'hdead_beec);
        cp0ReadCheck("regAccess EPC", cp0Pkg::regEPC, 32'hdead_beec);
        expectEq("regAccess epc port", 32'hdead_beec, epc);
        // Cause ignores software writes
        cp0Write(cp0Pkg::regCause, 32'hffff_ffff);
        cp0ReadCheck("regAccess Cause", cp0Pkg::regCause, 32'd0);
        cp0Write(5'd3, 32'h5a5a_5a5a);
        cp0ReadCheck("regAccess unknown 3", 5'd3, 32'd0);
        cp0ReadCheck("regAccess unknown 31", 5'd31, 32'd0);
        cp0Write(cp0Pkg::regSR, 32'd0);
    endtask

    task automatic testExcEntry();
        faultEntry("entry RI", fRi, randPc(), randBit(), codeRI);
        faultEntry("entry Sys", fSys, randPc(), randBit(), codeSys);
        faultEntry("entry Ov", fOv, randPc(), randBit(), codeOv);
        faultEntry("entry load", fLoad, randPc(), randBit(), codeAdEL);
        faultEntry("entry store", fStore, randPc(), randBit(), codeAdES);
        // two flags, higher priority wins
        faultEntry("entry Sys+Ov", fSys | fOv, randPc(), randBit(), codeSys);
        faultEntry("entry RI+load", fRi | fLoad, randPc(), randBit(), codeRI);
        faultEntry("entry load+store", fLoad | fStore, randPc(), randBit(), codeAdEL);
        // misaligned fetch beats everything
        faultEntry("entry misaligned", 5'd0, randPc() | 32'h2, randBit(), codeAdEL);
        faultEntry("entry misaligned+Ov", fOv, randPc() | 32'h1, randBit(), codeAdEL);
    endtask

    task automatic testExlReturn();
        logic [31:0] pcA;
        logic [31:0] pcB;
        pcA = randPc();
        pcB = randPc();
        cp0Write(cp0Pkg::regSR, 32'd0);
        @(posedge clk);
        faults <= fSys;
        pc     <= pcA;
        bd     <= 1'b0;
        @(negedge clk);
        expectEq("exl first req", 32'd1, req);
        // EXL now set, second fault is dropped
        @(posedge clk);
        pc <= pcB;
        @(negedge clk);
        expectEq("exl blocked req", 32'd0, req);
        @(posedge clk);
        faults <= 5'd0;
        eret   <= 1'b1;
        @(negedge clk);
        expectEq("exl epc kept", pcA, epc);
        @(posedge clk);
        eret   <= 1'b0;
        faults <= fSys;
        @(negedge clk);
        expectEq("exl req after eret", 32'd1, req);
        @(posedge clk);
        faults <= 5'd0;
        pc     <= 32'd0;
        @(negedge clk);
        expectEq("exl epc second", pcB, epc);
    endtask

    task automatic testMasking();
        // every mask but line 11, IE on
        cp0Write(cp0Pkg::regSR, 32'h0000_f401);
        @(posedge clk);
        extIrq <= 4'b0001;
        reqStaysLow("mask bit clear", 6);
        // line 11 unmasked but IE off
        cp0Write(cp0Pkg::regSR, 32'h0000_0800);
        reqStaysLow("mask IE clear", 4);
        @(posedge clk);
        extIrq <= 4'b0000;
        // let the synchronizer drain
        repeat (3) @(posedge clk);
        cp0Write(cp0Pkg::regSR, 32'h0000_0801);
        @(posedge clk);
        extIrq <= 4'b0001;
        waitReq("mask enabled", 3);
        cp0ReadCheck("mask Cause", cp0Pkg::regCause, 32'h0000_0800);
        @(posedge clk);
        extIrq <= 4'b0000;
        cp0Write(cp0Pkg::regSR, 32'd0);
    endtask

    task automatic testTimer();
        tmrWrite(cp0Pkg::tmrPreset, timerN);
        cp0Write(cp0Pkg::regSR, 32'h0000_0401);
        // enable plus irqMask, one-shot
        tmrWrite(cp0Pkg::tmrCtrl, 32'h0000_0009);
        waitReq("timer one-shot", timerN + 3);
        cp0ReadCheck("timer Cause", cp0Pkg::regCause, 32'h0000_0400);
        // one-shot line stays up each time EXL clears
        repeat (2) begin
            cp0Write(cp0Pkg::regSR, 32'h0000_0401);
            @(negedge clk);
            expectEq("timer irq persists", 32'd1, req);
        end
        @(posedge clk);
        tmrAddr <= cp0Pkg::tmrCount;
        @(negedge clk);
        expectEq("timer count at zero", 32'd0, tmrRdata);
        cp0Write(cp0Pkg::regSR, 32'd0);
        // enable plus auto-reload, no interrupt
        tmrWrite(cp0Pkg::tmrCtrl, 32'h0000_0003);
        @(posedge clk);
        tmrAddr <= cp0Pkg::tmrCount;
        waitCount("timer reaches zero", 32'd0, timerN + 4);
        waitCount("timer reload", timerN, 3);
        tmrWrite(cp0Pkg::tmrCtrl, 32'd0);
    endtask

    task automatic testGenerator();
        // line 12 unmasked, IE on
        cp0Write(cp0Pkg::regSR, 32'h0000_1001);
        @(posedge clk);
        genPulse <= 1'b1;
        @(posedge clk);
        genPulse <= 1'b0;
        @(negedge clk);
        expectEq("gen ack", 32'd1, genAck);
        expectEq("gen req", 32'd1, req);
        // ack clears the latch as the handler is entered
        @(posedge clk);
        @(negedge clk);
        expectEq("gen ack drops", 32'd0, genAck);
        cp0Write(cp0Pkg::regSR, 32'h0000_1001);
        @(negedge clk);
        expectEq("gen no new req", 32'd0, req);
        cp0ReadCheck("gen Cause pending clear", cp0Pkg::regCause, 32'd0);
    endtask

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        pc       = 32'd0;
        bd       = 1'b0;
        faults   = 5'd0;
        eret     = 1'b0;
        cp0Addr  = 5'd0;
        cp0Wdata = 32'd0;
        cp0We    = 1'b0;
        tmrAddr  = 2'd0;
        tmrWdata = 32'd0;
        tmrWe    = 1'b0;
        extIrq   = 4'd0;
        genPulse = 1'b0;
        errors   = 0;
        checks   = 0;
        seed     = 32'h7b49_47d5;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        expectEq("reset req", 32'd0, req);
        expectEq("reset genAck", 32'd0, genAck);
        testRegAccess();
        testExcEntry();
        testExlReturn();
        testMasking();
        testTimer();
        testGenerator();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // hang guard
    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, tests did not finish", watchdogCycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* verilog.f */
src/cp0Pkg.sv
src/excEncoder.sv
src/cp0Regs.sv
src/countTimer.sv
src/intSources.sv
src/excUnit.sv
dv/excUnitTb.sv
